// ==== ser_pkg.sv ====
package ser_pkg;

   // locale is the conflict key, two tasks with equal locale never run together
   typedef logic [15:0] locale_t;

   // task queue slot that follows a task through dispatch
   typedef logic [5:0] slot_t;

   typedef struct packed {
      locale_t     locale;
      logic [15:0] ts;
      logic [3:0]  ttype;
   } task_t;

   // register map
   localparam logic [7:0] REG_SIZE_CONTROL = 8'h00;
   localparam logic [7:0] REG_MAX_RUNNING  = 8'h04;
   localparam logic [7:0] REG_READY_LIST   = 8'h08;
   localparam logic [7:0] REG_STATUS       = 8'h0c;

   // size control view of a register word
   typedef struct packed {
      logic [15:0] rsvd;
      logic [7:0]  full_thr;
      logic [7:0]  almost_full_thr;
   } size_ctl_t;

   // one data word, read either as thresholds or as a plain count
   typedef union packed {
      size_ctl_t   size_ctl;
      logic [31:0] count;
   } cfg_word_u;

   // running task limit after reset
   localparam logic [31:0] DEF_MAX_RUNNING = 32'd64;

endpackage

// ==== task_bus_if.sv ====
`timescale 1ns/1ps

// one task plus its queue slot, moved with a valid/ready handshake
interface task_bus_if;
   import ser_pkg::*;

   logic  valid;
   logic  ready;
   task_t tsk;
   slot_t slot;

   // producer side, holds valid and data until ready
   modport src (
      output valid,
      output tsk,
      output slot,
      input  ready
   );

   // consumer side
   modport dst (
      input  valid,
      input  tsk,
      input  slot,
      output ready
   );

endinterface

// ==== free_list.sv ====
`timescale 1ns/1ps

module free_list #(
   parameter int LOG_DEPTH = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 wr_en,
   input  logic                 rd_en,
   input  logic [LOG_DEPTH-1:0] wr_data,
   output logic [LOG_DEPTH-1:0] rd_data,
   output logic                 empty,
   output logic [LOG_DEPTH:0]   size
);

   localparam int DEPTH = 2 ** LOG_DEPTH;
   localparam int PW    = LOG_DEPTH + 1;

   logic [LOG_DEPTH-1:0] mem [DEPTH];

   // pointers carry one extra wrap bit so full and empty differ
   logic [PW-1:0] rd_ptr;
   logic [PW-1:0] wr_ptr;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         // preload every index, so the list starts full
         for (int k = 0; k < DEPTH; k++) begin
            mem[k] <= LOG_DEPTH'(k);
         end
         rd_ptr <= '0;
         wr_ptr <= PW'(DEPTH);
      end else begin
         if (wr_en) begin
            mem[wr_ptr[LOG_DEPTH-1:0]] <= wr_data;
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // head of the list is always presented
   assign rd_data = mem[rd_ptr[LOG_DEPTH-1:0]];

   // number of indices currently free
   assign size  = wr_ptr - rd_ptr;
   assign empty = (size == '0);

endmodule

// ==== task_intake.sv ====
`timescale 1ns/1ps

module task_intake (
   input  logic           clk,
   input  logic           rstn,
   input  logic           in_valid,
   output logic           in_ready,
   input  ser_pkg::task_t in_task,
   input  ser_pkg::slot_t in_slot,
   task_bus_if.src        bus
);
   import ser_pkg::*;

   logic  hold_vld;
   task_t hold_task;
   slot_t hold_slot;

   // accept when empty, or when the held task leaves this cycle
   assign in_ready = !hold_vld | bus.ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         hold_vld <= 1'b0;
      end else if (in_valid && in_ready) begin
         hold_vld <= 1'b1;
      end else if (bus.ready) begin
         hold_vld <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         hold_task <= in_task;
         hold_slot <= in_slot;
      end
   end

   // offer to the serializer straight from the register
   assign bus.valid = hold_vld;
   assign bus.tsk   = hold_task;
   assign bus.slot  = hold_slot;

endmodule

// ==== conflict_serializer.sv ====
`timescale 1ns/1ps

module conflict_serializer #(
   parameter int LIST_LOG  = 3,
   parameter int N_THREADS = 4
) (
   input  logic                         clk,
   input  logic                         rstn,
   task_bus_if.dst                      bus,
   output logic                         out_valid,
   input  logic                         out_ready,
   output ser_pkg::task_t               out_task,
   output ser_pkg::slot_t               out_slot,
   output logic [$clog2(N_THREADS)-1:0] out_thread,
   input  logic                         unlock_valid,
   input  logic [$clog2(N_THREADS)-1:0] unlock_thread,
   input  logic [7:0]                   full_thr,
   input  logic [7:0]                   almost_full_thr,
   input  logic [31:0]                  max_running,
   output logic                         almost_full,
   output logic                         all_idle,
   output logic [2**LIST_LOG-1:0]       list_valid,
   output logic [2**LIST_LOG-1:0]       list_conflict,
   output logic [7:0]                   free_threads,
   output logic [7:0]                   n_running
);
   import ser_pkg::*;

   localparam int DEPTH = 2 ** LIST_LOG;
   localparam int TLOG  = $clog2(N_THREADS);
   localparam int LW    = LIST_LOG + 1;

   // ordered ready list, entry 0 is the oldest pending task
   logic [LIST_LOG-1:0] lid [DEPTH];
   locale_t             lloc [DEPTH];
   logic [DEPTH-1:0]    lvld;
   logic [DEPTH-1:0]    lcfl;
   logic [LIST_LOG-1:0] nxt_id [DEPTH];
   locale_t             nxt_loc [DEPTH];
   logic [DEPTH-1:0]    nxt_vld;
   logic [DEPTH-1:0]    nxt_cfl;

   // task data lives by id and does not shift
   task_t st_task [DEPTH];
   slot_t st_slot [DEPTH];

   // locale held by each busy thread
   locale_t        run_loc [N_THREADS];
   logic [N_THREADS-1:0] run_vld;
   logic [7:0]     run_cnt;

   logic [DEPTH-1:0]    elig;
   logic [DEPTH-1:0]    ul_match;
   logic [DEPTH-1:0]    ul_first;
   logic [LIST_LOG-1:0] sel;
   logic [LIST_LOG-1:0] ins_loc;
   logic [LIST_LOG-1:0] ins_pos;
   logic [LIST_LOG-1:0] new_id;
   logic [LW-1:0]       id_free_size;
   logic [LW-1:0]       occ;
   logic [TLOG:0]       thr_free_size;
   logic                id_empty;
   logic                thr_empty;
   locale_t             ul_loc;
   logic                issue;
   logic                ins;
   logic                ins_conflict;

   // index of the lowest set bit, 0 when none
   function automatic logic [LIST_LOG-1:0] first_set(input logic [DEPTH-1:0] v);
      logic [LIST_LOG-1:0] idx;
      idx = '0;
      for (int k = DEPTH - 1; k >= 0; k--) begin
         if (v[k]) begin
            idx = LIST_LOG'(k);
         end
      end
      return idx;
   endfunction

   // issue side
   assign elig      = lvld & ~lcfl;
   assign sel       = first_set(elig);
   assign out_valid = (|elig) & !thr_empty & (run_cnt < max_running);
   assign issue     = out_valid & out_ready;
   assign out_task  = st_task[lid[sel]];
   assign out_slot  = st_slot[lid[sel]];

   // insert side, the list stays packed toward the head
   assign occ       = LW'(DEPTH) - id_free_size;
   assign bus.ready = !id_empty & (occ < full_thr);
   assign ins       = bus.valid & bus.ready;
   assign ins_loc   = first_set(~lvld);
   // one slot closer to the head when an issue shifts the list
   assign ins_pos   = issue ? ins_loc - 1'b1 : ins_loc;

   always_comb begin
      ins_conflict = 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
         if (lvld[i] && (lloc[i] == bus.tsk.locale)) begin
            ins_conflict = 1'b1;
         end
      end
      // a thread unlocking now no longer holds its locale
      for (int j = 0; j < N_THREADS; j++) begin
         if (run_vld[j] && (run_loc[j] == bus.tsk.locale) &&
             !(unlock_valid && (unlock_thread == TLOG'(j)))) begin
            ins_conflict = 1'b1;
         end
      end
   end

   // unlock releases the oldest waiter on that locale
   assign ul_loc = run_loc[unlock_thread];

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         ul_match[i] = unlock_valid & lvld[i] & lcfl[i] & (lloc[i] == ul_loc);
      end
   end

   assign ul_first = ul_match & (~ul_match + 1'b1);

   free_list #(
      .LOG_DEPTH (LIST_LOG)
   ) u_id_list (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (issue),
      .rd_en   (ins),
      .wr_data (lid[sel]),
      .rd_data (new_id),
      .empty   (id_empty),
      .size    (id_free_size)
   );

   free_list #(
      .LOG_DEPTH (TLOG)
   ) u_thread_list (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (unlock_valid),
      .rd_en   (issue),
      .wr_data (unlock_thread),
      .rd_data (out_thread),
      .empty   (thr_empty),
      .size    (thr_free_size)
   );

   // next list state: shift over the issued entry, clear, then insert
   always_comb begin
      nxt_id  = lid;
      nxt_loc = lloc;
      nxt_vld = lvld;
      nxt_cfl = lcfl & ~ul_first;
      if (issue) begin
         for (int i = 0; i < DEPTH - 1; i++) begin
            if (i >= sel) begin
               nxt_id[i]  = lid[i+1];
               nxt_loc[i] = lloc[i+1];
               nxt_vld[i] = lvld[i+1];
               nxt_cfl[i] = lcfl[i+1] & ~ul_first[i+1];
            end
         end
         nxt_vld[DEPTH-1] = 1'b0;
         nxt_cfl[DEPTH-1] = 1'b0;
      end
      if (ins) begin
         nxt_id[ins_pos]  = new_id;
         nxt_loc[ins_pos] = bus.tsk.locale;
         nxt_vld[ins_pos] = 1'b1;
         nxt_cfl[ins_pos] = ins_conflict;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         lvld <= '0;
         lcfl <= '0;
      end else begin
         lvld <= nxt_vld;
         lcfl <= nxt_cfl;
      end
   end

   always_ff @(posedge clk) begin
      lid  <= nxt_id;
      lloc <= nxt_loc;
      if (ins) begin
         st_task[new_id] <= bus.tsk;
         st_slot[new_id] <= bus.slot;
      end
   end

   // running table, a thread cannot issue and unlock in one cycle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         run_vld <= '0;
      end else begin
         for (int j = 0; j < N_THREADS; j++) begin
            if (issue && (out_thread == TLOG'(j))) begin
               run_vld[j] <= 1'b1;
            end else if (unlock_valid && (unlock_thread == TLOG'(j))) begin
               run_vld[j] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int j = 0; j < N_THREADS; j++) begin
         if (issue && (out_thread == TLOG'(j))) begin
            run_loc[j] <= out_task.locale;
         end
      end
   end

   // running count from issues and unlocks
   always_ff @(posedge clk) begin
      if (!rstn) begin
         run_cnt <= '0;
      end else if (issue && !unlock_valid) begin
         run_cnt <= run_cnt + 1'b1;
      end else if (unlock_valid && !issue) begin
         run_cnt <= run_cnt - 1'b1;
      end
   end

   assign almost_full   = (occ >= almost_full_thr);
   assign all_idle      = (lvld == '0) && (run_vld == '0);
   assign list_valid    = lvld;
   assign list_conflict = lcfl;
   assign free_threads  = 8'(thr_free_size);
   assign n_running     = run_cnt;

endmodule

// ==== ser_regs.sv ====
`timescale 1ns/1ps

module ser_regs #(
   parameter int LIST_LOG = 3
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   reg_wvalid,
   input  logic [7:0]             reg_waddr,
   input  logic [31:0]            reg_wdata,
   input  logic                   reg_arvalid,
   input  logic [7:0]             reg_araddr,
   output logic                   reg_rvalid,
   output logic [31:0]            reg_rdata,
   input  logic [2**LIST_LOG-1:0] list_valid,
   input  logic [2**LIST_LOG-1:0] list_conflict,
   input  logic [7:0]             free_threads,
   input  logic [7:0]             n_running,
   output logic [7:0]             full_thr,
   output logic [7:0]             almost_full_thr,
   output logic [31:0]            max_running
);
   import ser_pkg::*;

   localparam int DEPTH = 2 ** LIST_LOG;

   cfg_word_u wr_word;
   cfg_word_u size_word;

   assign wr_word = reg_wdata;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         // defaults follow the list depth
         almost_full_thr <= 8'(DEPTH - 2);
         full_thr        <= 8'(DEPTH - 1);
         max_running     <= DEF_MAX_RUNNING;
      end else if (reg_wvalid) begin
         case (reg_waddr)
            REG_SIZE_CONTROL: begin
               almost_full_thr <= wr_word.size_ctl.almost_full_thr;
               full_thr        <= wr_word.size_ctl.full_thr;
            end
            REG_MAX_RUNNING: max_running <= wr_word.count;
            default: ;
         endcase
      end
   end

   // thresholds packed back into one word for readback
   always_comb begin
      size_word                          = '0;
      size_word.size_ctl.almost_full_thr = almost_full_thr;
      size_word.size_ctl.full_thr        = full_thr;
   end

   // read data one cycle after the request
   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_arvalid) begin
         case (reg_araddr)
            REG_SIZE_CONTROL: reg_rdata <= size_word.count;
            REG_MAX_RUNNING:  reg_rdata <= max_running;
            REG_READY_LIST:   reg_rdata <= 32'({list_valid, list_conflict});
            REG_STATUS:       reg_rdata <= {16'h0000, free_threads, n_running};
            default:          reg_rdata <= 32'h0;
         endcase
      end
   end

endmodule

// ==== task_dispatch_top.sv ====
`timescale 1ns/1ps

module task_dispatch_top #(
   parameter int LIST_LOG  = 3,
   parameter int N_THREADS = 4
) (
   input  logic                         clk,
   input  logic                         rstn,
   // task queue side
   input  logic                         in_valid,
   output logic                         in_ready,
   input  ser_pkg::task_t               in_task,
   input  ser_pkg::slot_t               in_slot,
   // core side
   output logic                         out_valid,
   input  logic                         out_ready,
   output ser_pkg::task_t               out_task,
   output ser_pkg::slot_t               out_slot,
   output logic [$clog2(N_THREADS)-1:0] out_thread,
   input  logic                         unlock_valid,
   input  logic [$clog2(N_THREADS)-1:0] unlock_thread,
   // register access
   input  logic                         reg_wvalid,
   input  logic [7:0]                   reg_waddr,
   input  logic [31:0]                  reg_wdata,
   input  logic                         reg_arvalid,
   input  logic [7:0]                   reg_araddr,
   output logic                         reg_rvalid,
   output logic [31:0]                  reg_rdata,
   // status levels
   output logic                         almost_full,
   output logic                         all_idle
);

   logic [7:0]             full_thr;
   logic [7:0]             almost_full_thr;
   logic [31:0]            max_running;
   logic [2**LIST_LOG-1:0] list_valid;
   logic [2**LIST_LOG-1:0] list_conflict;
   logic [7:0]             free_threads;
   logic [7:0]             n_running;

   task_bus_if bus ();

   task_intake u_intake (
      .clk      (clk),
      .rstn     (rstn),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .in_task  (in_task),
      .in_slot  (in_slot),
      .bus      (bus.src)
   );

   conflict_serializer #(
      .LIST_LOG  (LIST_LOG),
      .N_THREADS (N_THREADS)
   ) u_serializer (
      .clk             (clk),
      .rstn            (rstn),
      .bus             (bus.dst),
      .out_valid       (out_valid),
      .out_ready       (out_ready),
      .out_task        (out_task),
      .out_slot        (out_slot),
      .out_thread      (out_thread),
      .unlock_valid    (unlock_valid),
      .unlock_thread   (unlock_thread),
      .full_thr        (full_thr),
      .almost_full_thr (almost_full_thr),
      .max_running     (max_running),
      .almost_full     (almost_full),
      .all_idle        (all_idle),
      .list_valid      (list_valid),
      .list_conflict   (list_conflict),
      .free_threads    (free_threads),
      .n_running       (n_running)
   );

   ser_regs #(
      .LIST_LOG (LIST_LOG)
   ) u_regs (
      .clk             (clk),
      .rstn            (rstn),
      .reg_wvalid      (reg_wvalid),
      .reg_waddr       (reg_waddr),
      .reg_wdata       (reg_wdata),
      .reg_arvalid     (reg_arvalid),
      .reg_araddr      (reg_araddr),
      .reg_rvalid      (reg_rvalid),
      .reg_rdata       (reg_rdata),
      .list_valid      (list_valid),
      .list_conflict   (list_conflict),
      .free_threads    (free_threads),
      .n_running       (n_running),
      .full_thr        (full_thr),
      .almost_full_thr (almost_full_thr),
      .max_running     (max_running)
   );

endmodule

// ==== tb_assert.sv ====
`timescale 1ns/1ps

module tb_assert #(
   parameter int LIST_LOG  = 3,
   parameter int N_THREADS = 4
) (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         in_valid,
   input  logic                         in_ready,
   input  ser_pkg::task_t               in_task,
   input  ser_pkg::slot_t               in_slot,
   input  logic                         out_valid,
   input  logic                         out_ready,
   input  ser_pkg::task_t               out_task,
   input  ser_pkg::slot_t               out_slot,
   input  logic [$clog2(N_THREADS)-1:0] out_thread,
   input  logic                         unlock_valid,
   input  logic [$clog2(N_THREADS)-1:0] unlock_thread,
   input  logic                         reg_wvalid,
   input  logic [7:0]                   reg_waddr,
   input  logic [31:0]                  reg_wdata,
   input  logic                         reg_arvalid,
   input  logic [7:0]                   reg_araddr,
   input  logic                         reg_rvalid,
   input  logic [31:0]                  reg_rdata,
   input  logic                         almost_full,
   input  logic                         all_idle
);
   import ser_pkg::*;

   localparam int DEPTH   = 2 ** LIST_LOG;
   localparam int N_SEEN  = 16;
   localparam int TRK_LOG = 7;
   localparam int N_TRACK = 2 ** TRK_LOG;

   // shadow of the threads that hold a locale
   logic [N_THREADS-1:0] busy;
   locale_t              busy_loc [N_THREADS];
   int                   busy_cnt;
   logic [31:0]          lim;
   logic [7:0]           f_thr;
   logic [7:0]           af_thr;
   logic [31:0]          rd_exp;
   cfg_word_u            wr_word;
   int                   n_acc;
   int                   n_iss;
   int                   fail_cnt = 0;

   // task waiting in the intake register, and tasks already in the ready list
   logic                 in_held;
   int                   list_occ;

   // every accepted task with its slot, by timestamp
   task_t                acc_task [N_TRACK];
   slot_t                acc_slot [N_TRACK];

   // last issued timestamp of every locale seen so far
   locale_t           seen_loc [N_SEEN];
   logic [15:0]       seen_ts [N_SEEN];
   logic [N_SEEN-1:0] seen_vld;
   int                seen_slot;

   logic issue;
   logic moved;
   logic loc_busy;
   logic ts_ok;
   logic payload_ok;

   assign issue   = out_valid && out_ready;
   assign wr_word = reg_wdata;
   // a held task leaves whenever the intake can take a new one
   assign moved   = in_held && in_ready;

   assign payload_ok = (out_task == acc_task[out_task.ts[TRK_LOG-1:0]]) &&
                       (out_slot == acc_slot[out_task.ts[TRK_LOG-1:0]]);

   always_comb begin
      busy_cnt = 0;
      loc_busy = 1'b0;
      for (int j = 0; j < N_THREADS; j++) begin
         if (busy[j]) begin
            busy_cnt++;
            if (busy_loc[j] == out_task.locale) begin
               loc_busy = 1'b1;
            end
         end
      end
   end

   always_comb begin
      ts_ok     = 1'b1;
      seen_slot = 0;
      // first free entry, then the entry already holding this locale
      for (int k = N_SEEN - 1; k >= 0; k--) begin
         if (!seen_vld[k]) begin
            seen_slot = k;
         end
      end
      for (int k = N_SEEN - 1; k >= 0; k--) begin
         if (seen_vld[k] && (seen_loc[k] == out_task.locale)) begin
            seen_slot = k;
            if (out_task.ts <= seen_ts[k]) begin
               ts_ok = 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy     <= '0;
         seen_vld <= '0;
         lim      <= 32'd64;
         af_thr   <= 8'(DEPTH - 2);
         f_thr    <= 8'(DEPTH - 1);
         in_held  <= 1'b0;
         list_occ <= 0;
         n_acc    <= 0;
         n_iss    <= 0;
      end else begin
         if (in_valid && in_ready) begin
            n_acc                             <= n_acc + 1;
            acc_task[in_task.ts[TRK_LOG-1:0]] <= in_task;
            acc_slot[in_task.ts[TRK_LOG-1:0]] <= in_slot;
         end
         in_held  <= (in_valid && in_ready) || (in_held && !in_ready);
         list_occ <= list_occ + int'(moved) - int'(issue);
         if (issue) begin
            n_iss                <= n_iss + 1;
            busy[out_thread]     <= 1'b1;
            busy_loc[out_thread] <= out_task.locale;
            seen_vld[seen_slot]  <= 1'b1;
            seen_loc[seen_slot]  <= out_task.locale;
            seen_ts[seen_slot]   <= out_task.ts;
         end
         if (unlock_valid) begin
            busy[unlock_thread] <= 1'b0;
         end
         if (reg_wvalid && (reg_waddr == REG_MAX_RUNNING)) begin
            lim <= reg_wdata;
         end
         if (reg_wvalid && (reg_waddr == REG_SIZE_CONTROL)) begin
            f_thr  <= wr_word.size_ctl.full_thr;
            af_thr <= wr_word.size_ctl.almost_full_thr;
         end
      end
   end

   // expected read data, captured with the request
   always_ff @(posedge clk) begin
      if (reg_arvalid) begin
         if (reg_araddr == REG_MAX_RUNNING) begin
            rd_exp <= lim;
         end else begin
            rd_exp <= {16'h0000, f_thr, af_thr};
         end
      end
   end

   // sampled on the falling edge, where every handshake signal is settled
   a_locale_free: assert property (@(negedge clk) disable iff (!rstn)
      issue |-> !loc_busy)
      else begin
         fail_cnt++;
         $error("issued locale %h is still running", out_task.locale);
      end

   a_thread_free: assert property (@(negedge clk) disable iff (!rstn)
      issue |-> !busy[out_thread])
      else begin
         fail_cnt++;
         $error("task issued to busy thread %0d", out_thread);
      end

   a_locale_order: assert property (@(negedge clk) disable iff (!rstn)
      issue |-> ts_ok)
      else begin
         fail_cnt++;
         $error("locale %h issued out of order, ts %0d", out_task.locale, out_task.ts);
      end

   a_payload: assert property (@(negedge clk) disable iff (!rstn)
      issue |-> payload_ok)
      else begin
         fail_cnt++;
         $error("task ts %0d issued with wrong data or slot", out_task.ts);
      end

   a_run_limit: assert property (@(negedge clk) disable iff (!rstn)
      issue |-> (busy_cnt < int'(lim)))
      else begin
         fail_cnt++;
         $error("issue with %0d running, limit %0d", busy_cnt, lim);
      end

   // a held task waits while the list is at the full threshold
   a_intake_ready: assert property (@(negedge clk) disable iff (!rstn)
      in_ready == (!in_held || ((list_occ < int'(f_thr)) && (list_occ < DEPTH))))
      else begin
         fail_cnt++;
         $error("in_ready %0b with %0d tasks listed", in_ready, list_occ);
      end

   a_almost_full: assert property (@(negedge clk) disable iff (!rstn)
      almost_full == (list_occ >= int'(af_thr)))
      else begin
         fail_cnt++;
         $error("almost_full %0b with %0d tasks listed", almost_full, list_occ);
      end

   a_read_latency: assert property (@(negedge clk) disable iff (!rstn)
      reg_rvalid == $past(reg_arvalid))
      else begin
         fail_cnt++;
         $error("reg_rvalid not one cycle after reg_arvalid");
      end

   a_read_back: assert property (@(negedge clk) disable iff (!rstn)
      reg_arvalid && ((reg_araddr == REG_MAX_RUNNING) || (reg_araddr == REG_SIZE_CONTROL))
      |=> reg_rdata == rd_exp)
      else begin
         fail_cnt++;
         $error("register read %h, expected %h", reg_rdata, rd_exp);
      end

   // idle for two cycles with no new task means the intake is empty too
   a_all_issued: assert property (@(negedge clk) disable iff (!rstn)
      all_idle && $past(all_idle) && !$past(in_valid) |-> (n_acc == n_iss))
      else begin
         fail_cnt++;
         $error("idle with %0d accepted and %0d issued", n_acc, n_iss);
      end

endmodule

// ==== tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
   import ser_pkg::*;

   localparam int LIST_LOG        = 3;
   localparam int N_THREADS       = 4;
   localparam int TLOG            = $clog2(N_THREADS);
   localparam int CLK_PERIOD      = 100;
   localparam int TASKS_PER_PHASE = 40;
   localparam int N_TASKS         = 3 * TASKS_PER_PHASE;
   localparam int WATCHDOG_CYCLES = 200 * N_TASKS + 1000;

   logic            clk;
   logic            rstn;
   logic            in_valid;
   logic            in_ready;
   task_t           in_task;
   slot_t           in_slot;
   logic            out_valid;
   logic            out_ready;
   task_t           out_task;
   slot_t           out_slot;
   logic [TLOG-1:0] out_thread;
   logic            unlock_valid;
   logic [TLOG-1:0] unlock_thread;
   logic            reg_wvalid;
   logic [7:0]      reg_waddr;
   logic [31:0]     reg_wdata;
   logic            reg_arvalid;
   logic [7:0]      reg_araddr;
   logic            reg_rvalid;
   logic [31:0]     reg_rdata;
   logic            almost_full;
   logic            all_idle;

   logic [31:0]          lfsr = 32'h7481;
   int                   to_send;
   int                   n_sent;
   int                   n_accepted;
   int                   n_issued;
   logic [15:0]          ts_next;
   // core model, busy threads and their remaining cycles
   logic [N_THREADS-1:0] core_busy;
   int                   core_left [N_THREADS];

   task_dispatch_top #(
      .LIST_LOG  (LIST_LOG),
      .N_THREADS (N_THREADS)
   ) dut (.*);

   bind task_dispatch_top tb_assert #(
      .LIST_LOG  (LIST_LOG),
      .N_THREADS (N_THREADS)
   ) u_chk (
      .clk           (clk),
      .rstn          (rstn),
      .in_valid      (in_valid),
      .in_ready      (in_ready),
      .in_task       (in_task),
      .in_slot       (in_slot),
      .out_valid     (out_valid),
      .out_ready     (out_ready),
      .out_task      (out_task),
      .out_slot      (out_slot),
      .out_thread    (out_thread),
      .unlock_valid  (unlock_valid),
      .unlock_thread (unlock_thread),
      .reg_wvalid    (reg_wvalid),
      .reg_waddr     (reg_waddr),
      .reg_wdata     (reg_wdata),
      .reg_arvalid   (reg_arvalid),
      .reg_araddr    (reg_araddr),
      .reg_rvalid    (reg_rvalid),
      .reg_rdata     (reg_rdata),
      .almost_full   (almost_full),
      .all_idle      (all_idle)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // galois LFSR, shifts right
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'hA3000000;
      end
      return n;
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // only four locales, so conflicts are frequent
   function automatic locale_t locale_of(input logic [1:0] idx);
      case (idx)
         2'd0:    return 16'h0a11;
         2'd1:    return 16'h1b22;
         2'd2:    return 16'h2c33;
         default: return 16'h3d44;
      endcase
   endfunction

   // one clock cycle: sample handshakes before the edge, drive after it
   task automatic tick();
      logic            fire;
      logic            acc;
      logic [TLOG-1:0] fire_thr;
      logic [31:0]     r;
      @(negedge clk);
      fire     = out_valid && out_ready;
      fire_thr = out_thread;
      acc      = in_valid && in_ready;
      @(posedge clk);
      #10;
      reg_wvalid   = 1'b0;
      reg_arvalid  = 1'b0;
      unlock_valid = 1'b0;
      for (int j = 0; j < N_THREADS; j++) begin
         if (core_busy[j] && core_left[j] > 0) begin
            core_left[j]--;
         end
      end
      // at most one unlock per cycle, the others wait
      for (int j = 0; j < N_THREADS; j++) begin
         if (core_busy[j] && core_left[j] == 0 && !unlock_valid) begin
            unlock_valid  = 1'b1;
            unlock_thread = TLOG'(j);
            core_busy[j]  = 1'b0;
         end
      end
      if (fire) begin
         take_bits(3, r);
         core_busy[fire_thr] = 1'b1;
         core_left[fire_thr] = int'(r) + 1;
         n_issued++;
      end
      take_bits(2, r);
      out_ready = (r[1:0] != 2'b00);
      if (acc) begin
         n_accepted++;
         ts_next++;
         in_valid = 1'b0;
      end
      if (!in_valid && to_send > 0) begin
         take_bits(2, r);
         in_task.locale = locale_of(r[1:0]);
         in_task.ts     = ts_next;
         take_bits(4, r);
         in_task.ttype  = r[3:0];
         in_slot        = slot_t'(n_sent);
         in_valid       = 1'b1;
         n_sent++;
         to_send--;
      end
   endtask

   task automatic send_tasks(input int n);
      to_send = n;
      while (to_send > 0 || in_valid) begin
         tick();
      end
   endtask

   task automatic write_reg(input logic [7:0] addr, input cfg_word_u data);
      reg_wvalid = 1'b1;
      reg_waddr  = addr;
      reg_wdata  = data.count;
      tick();
   endtask

   task automatic read_reg(input logic [7:0] addr);
      reg_arvalid = 1'b1;
      reg_araddr  = addr;
      tick();
      tick();
   endtask

   initial begin
      cfg_word_u w;
      rstn          = 1'b0;
      in_valid      = 1'b0;
      in_task       = '0;
      in_slot       = '0;
      out_ready     = 1'b0;
      unlock_valid  = 1'b0;
      unlock_thread = '0;
      reg_wvalid    = 1'b0;
      reg_waddr     = '0;
      reg_wdata     = '0;
      reg_arvalid   = 1'b0;
      reg_araddr    = '0;
      core_busy     = '0;
      to_send       = 0;
      n_sent        = 0;
      n_accepted    = 0;
      n_issued      = 0;
      ts_next       = '0;
      repeat (5) @(posedge clk);
      #10;
      rstn = 1'b1;

      send_tasks(TASKS_PER_PHASE);
      read_reg(REG_MAX_RUNNING);

      // middle phase with at most two tasks running
      w.count = 32'd2;
      write_reg(REG_MAX_RUNNING, w);
      read_reg(REG_MAX_RUNNING);
      send_tasks(TASKS_PER_PHASE);
      w.count = 32'd64;
      write_reg(REG_MAX_RUNNING, w);
      read_reg(REG_MAX_RUNNING);

      // tighter thresholds through the size view
      w                          = '0;
      w.size_ctl.full_thr        = 8'd5;
      w.size_ctl.almost_full_thr = 8'd3;
      write_reg(REG_SIZE_CONTROL, w);
      read_reg(REG_SIZE_CONTROL);
      send_tasks(TASKS_PER_PHASE);

      // let every thread finish
      while (!(all_idle && n_issued == n_accepted)) begin
         tick();
      end
      repeat (4) tick();

      if (dut.u_chk.fail_cnt == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         $display("ERR %0t: %0d assertion failures", $time, dut.u_chk.fail_cnt);
         $display("Checks failed");
         $fatal(1, "assertion failures at end of run");
      end
   end

   // stop at the first failed assertion
   initial begin
      while (dut.u_chk.fail_cnt == 0) begin
         @(posedge clk);
      end
      $display("ERR %0t: dispatch assertion failed", $time);
      $display("Checks failed");
      $fatal(1, "assertion failure");
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: dispatch did not drain within %0d cycles", WATCHDOG_CYCLES);
      $display("Checks failed");
      $fatal(1, "watchdog expired");
   end

endmodule

// ==== flist.f ====
ser_pkg.sv
task_bus_if.sv
free_list.sv
task_intake.sv
conflict_serializer.sv
ser_regs.sv
task_dispatch_top.sv
tb_assert.sv
tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f \
   -o tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All checks passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
